// File: source/cache_layout_pkg.sv
// Geometry is fixed at 32-bit words and 4-word lines; only the set count varies, per module
package cache_layout_pkg;

    // ------------------------------------------------------------
    // Processor side
    // ------------------------------------------------------------
    localparam int WORD_BITS      = 32;   // Data word width
    localparam int ADDR_BITS      = 30;   // Word address, byte offset already stripped
    localparam int WORD_SEL_BITS  = 2;    // Word within line

    // ------------------------------------------------------------
    // Line and array shape
    // ------------------------------------------------------------
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_BITS      = 128;  // Memory port width
    localparam int NUM_WAYS       = 2;    // LRU logic assumes exactly two

    // One cache line, seen two ways.
    // The memory port moves the flat vector, the processor side picks a word.
    // Word 0 sits in the low 32 bits.
    typedef union packed {
        logic [LINE_BITS-1:0]                      flat;
        logic [WORDS_PER_LINE-1:0][WORD_BITS-1:0] words;
    } cache_line_u;

endpackage

// File: source/cache_ctrl_pkg.sv
// Encodings shared by the miss controller and the way arrays; codes outside these are unused
package cache_ctrl_pkg;

    // ------------------------------------------------------------
    // Controller states
    // ------------------------------------------------------------
    // Write-allocate has no state of its own.
    // The write is finished by the retried hit after the refill.
    localparam logic [2:0] ST_IDLE  = 3'd0;  // Waiting for a miss
    localparam logic [2:0] ST_EVICT = 3'd1;  // Dirty victim going out
    localparam logic [2:0] ST_FILL  = 3'd2;  // Requested line coming in

    // ------------------------------------------------------------
    // Refill command, controller to ways
    // ------------------------------------------------------------
    localparam logic [1:0] FILL_NONE  = 2'd0;  // Arrays untouched by memory
    localparam logic [1:0] FILL_CLEAN = 2'd1;  // Load line, dirty bit cleared

endpackage

// File: source/cache_ways.sv
// Two ways only; tag and data arrays power up unknown and are qualified by the valid bits
`timescale 1ns/1ps

module cache_ways #(
    parameter int SET_BITS = 2
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   i_read,
    input  logic                                   i_write,
    input  logic [cache_layout_pkg::ADDR_BITS-1:0] i_addr,
    input  logic [cache_layout_pkg::WORD_BITS-1:0] i_wdata,
    input  logic [1:0]                             i_fill_cmd,
    input  cache_layout_pkg::cache_line_u          i_fill_line,
    output logic                                   o_hit,
    output logic [cache_layout_pkg::WORD_BITS-1:0] o_rdata,
    output logic                                   o_victim_dirty,
    output logic [cache_layout_pkg::ADDR_BITS-1:
                  SET_BITS+cache_layout_pkg::WORD_SEL_BITS] o_victim_tag,
    output cache_layout_pkg::cache_line_u          o_victim_line
);

    localparam int NUM_SETS = 1 << SET_BITS;
    localparam int TAG_LSB  = SET_BITS + cache_layout_pkg::WORD_SEL_BITS;
    localparam int TAG_BITS = cache_layout_pkg::ADDR_BITS - TAG_LSB;

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------
    logic [cache_layout_pkg::NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;
    logic [cache_layout_pkg::NUM_WAYS-1:0][NUM_SETS-1:0] dirty_q;
    logic [NUM_SETS-1:0]                                 lru_q;    // Names the older way

    logic [TAG_BITS-1:0]          tag_q  [cache_layout_pkg::NUM_WAYS][NUM_SETS];
    cache_layout_pkg::cache_line_u data_q [cache_layout_pkg::NUM_WAYS][NUM_SETS];

    // Address split
    logic [TAG_BITS-1:0]                       req_tag;
    logic [SET_BITS-1:0]                       set_idx;
    logic [cache_layout_pkg::WORD_SEL_BITS-1:0] word_sel;

    logic [cache_layout_pkg::NUM_WAYS-1:0] hit_way;
    logic                                  hit_idx;     // Which way hit
    logic                                  victim_way;
    logic                                  req_valid;
    logic                                  fill_en;
    cache_layout_pkg::cache_line_u         hit_line;

    assign req_tag  = i_addr[cache_layout_pkg::ADDR_BITS-1:TAG_LSB];
    assign set_idx  = i_addr[TAG_LSB-1:cache_layout_pkg::WORD_SEL_BITS];
    assign word_sel = i_addr[cache_layout_pkg::WORD_SEL_BITS-1:0];

    assign req_valid = i_read | i_write;
    assign fill_en   = (i_fill_cmd != cache_ctrl_pkg::FILL_NONE);

    // ------------------------------------------------------------
    // Lookup
    // ------------------------------------------------------------
    always_comb begin
        for (int w = 0; w < cache_layout_pkg::NUM_WAYS; w++) begin
            hit_way[w] = valid_q[w][set_idx] && (tag_q[w][set_idx] == req_tag);
        end
    end

    assign o_hit      = |hit_way;
    assign hit_idx    = hit_way[1];
    assign victim_way = lru_q[set_idx];

    assign hit_line = data_q[hit_idx][set_idx];
    assign o_rdata  = (i_read && o_hit) ? hit_line.words[word_sel]
                                        : '0;  // Zero unless a read hit

    // Victim info for the controller
    assign o_victim_dirty = dirty_q[victim_way][set_idx];
    assign o_victim_tag   = tag_q[victim_way][set_idx];
    assign o_victim_line  = data_q[victim_way][set_idx];

    // ------------------------------------------------------------
    // Status bits
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (req_valid && o_hit) begin
                lru_q[set_idx] <= ~hit_idx;  // Other way becomes the victim
                if (i_write) begin
                    dirty_q[hit_idx][set_idx] <= 1'b1;
                end
            end
            // Refill only happens while the request misses
            if (fill_en) begin
                valid_q[victim_way][set_idx] <= 1'b1;
                dirty_q[victim_way][set_idx] <= (i_fill_cmd != cache_ctrl_pkg::FILL_CLEAN);
            end
        end
    end

    // ------------------------------------------------------------
    // Tag and data arrays
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[victim_way][set_idx]  <= req_tag;
            data_q[victim_way][set_idx] <= i_fill_line;
        end else if (i_write && o_hit) begin
            data_q[hit_idx][set_idx].words[word_sel] <= i_wdata;  // Single word merge
        end
    end

endmodule

// File: source/cache_controller.sv
// One miss in flight; memory must hold i_mem_ready high for exactly one cycle per request
`timescale 1ns/1ps

module cache_controller #(
    parameter int SET_BITS = 2
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   i_read,
    input  logic                                   i_write,
    input  logic [cache_layout_pkg::ADDR_BITS-1:0] i_addr,
    input  logic                                   i_hit,
    input  logic                                   i_victim_dirty,
    input  logic [cache_layout_pkg::ADDR_BITS-1:
                  SET_BITS+cache_layout_pkg::WORD_SEL_BITS] i_victim_tag,
    input  cache_layout_pkg::cache_line_u          i_victim_line,
    input  logic                                   i_mem_ready,
    output logic                                   o_stall,
    output logic                                   o_mem_read,
    output logic                                   o_mem_write,
    output logic [cache_layout_pkg::ADDR_BITS-cache_layout_pkg::WORD_SEL_BITS-1:0] o_mem_addr,
    output logic [cache_layout_pkg::LINE_BITS-1:0] o_mem_wdata,
    output logic [1:0]                             o_fill_cmd
);

    localparam int LINE_ADDR_BITS = cache_layout_pkg::ADDR_BITS
                                  - cache_layout_pkg::WORD_SEL_BITS;

    logic [2:0]                state_q;
    logic [SET_BITS-1:0]       set_idx;
    logic [LINE_ADDR_BITS-1:0] req_line;   // Line address of the request
    logic                      req_valid;
    logic                      miss_start;
    logic                      evict_done;

    assign set_idx  = i_addr[SET_BITS+cache_layout_pkg::WORD_SEL_BITS-1:
                             cache_layout_pkg::WORD_SEL_BITS];
    assign req_line = i_addr[cache_layout_pkg::ADDR_BITS-1:cache_layout_pkg::WORD_SEL_BITS];

    assign req_valid  = i_read | i_write;
    assign miss_start = (state_q == cache_ctrl_pkg::ST_IDLE) && req_valid && !i_hit;
    assign evict_done = (state_q == cache_ctrl_pkg::ST_EVICT) && i_mem_ready;

    // ------------------------------------------------------------
    // Processor and way controls
    // ------------------------------------------------------------
    // Stall falls the cycle the retried access hits
    assign o_stall = req_valid & ~i_hit;

    // Refill lands on the same edge that completes the memory read
    assign o_fill_cmd = ((state_q == cache_ctrl_pkg::ST_FILL) && i_mem_ready)
                      ? cache_ctrl_pkg::FILL_CLEAN
                      : cache_ctrl_pkg::FILL_NONE;

    // ------------------------------------------------------------
    // Miss FSM and memory strobes
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= cache_ctrl_pkg::ST_IDLE;
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
        end else begin
            case (state_q)
                cache_ctrl_pkg::ST_IDLE: begin
                    if (miss_start) begin
                        if (i_victim_dirty) begin
                            state_q     <= cache_ctrl_pkg::ST_EVICT;
                            o_mem_write <= 1'b1;  // Write back first
                        end else begin
                            state_q    <= cache_ctrl_pkg::ST_FILL;
                            o_mem_read <= 1'b1;
                        end
                    end
                end

                cache_ctrl_pkg::ST_EVICT: begin
                    // Write turns straight into the refill read
                    if (i_mem_ready) begin
                        state_q     <= cache_ctrl_pkg::ST_FILL;
                        o_mem_write <= 1'b0;
                        o_mem_read  <= 1'b1;
                    end
                end

                cache_ctrl_pkg::ST_FILL: begin
                    if (i_mem_ready) begin
                        state_q    <= cache_ctrl_pkg::ST_IDLE;
                        o_mem_read <= 1'b0;
                    end
                end

                default: begin
                    state_q     <= cache_ctrl_pkg::ST_IDLE;
                    o_mem_read  <= 1'b0;
                    o_mem_write <= 1'b0;
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // Memory address and write data
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (miss_start && i_victim_dirty) begin
            o_mem_addr  <= {i_victim_tag, set_idx};  // Victim's own line
            o_mem_wdata <= i_victim_line.flat;
        end else if (miss_start || evict_done) begin
            o_mem_addr <= req_line;
        end
    end

endmodule

// File: source/l1_dcache.sv
// Processor must hold i_read or i_write with its address and data until o_stall is low
`timescale 1ns/1ps

module l1_dcache #(
    parameter int SET_BITS = 2  // Four sets by default
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    // Processor port
    input  logic                                   i_read,
    input  logic                                   i_write,
    input  logic [cache_layout_pkg::ADDR_BITS-1:0] i_addr,
    input  logic [cache_layout_pkg::WORD_BITS-1:0] i_wdata,
    output logic [cache_layout_pkg::WORD_BITS-1:0] o_rdata,
    output logic                                   o_stall,
    // Memory port
    output logic                                   o_mem_read,
    output logic                                   o_mem_write,
    output logic [cache_layout_pkg::ADDR_BITS-cache_layout_pkg::WORD_SEL_BITS-1:0] o_mem_addr,
    output logic [cache_layout_pkg::LINE_BITS-1:0] o_mem_wdata,
    input  logic [cache_layout_pkg::LINE_BITS-1:0] i_mem_rdata,
    input  logic                                   i_mem_ready
);

    // ------------------------------------------------------------
    // Ways to controller
    // ------------------------------------------------------------
    logic                                  hit;
    logic                                  victim_dirty;
    logic [cache_layout_pkg::ADDR_BITS-1:
           SET_BITS+cache_layout_pkg::WORD_SEL_BITS] victim_tag;
    cache_layout_pkg::cache_line_u         victim_line;
    logic [1:0]                            fill_cmd;

    cache_ways #(
        .SET_BITS       (SET_BITS)
    ) ways_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_read         (i_read),
        .i_write        (i_write),
        .i_addr         (i_addr),
        .i_wdata        (i_wdata),
        .i_fill_cmd     (fill_cmd),
        .i_fill_line    (i_mem_rdata),  // Refill taken straight off the bus
        .o_hit          (hit),
        .o_rdata        (o_rdata),
        .o_victim_dirty (victim_dirty),
        .o_victim_tag   (victim_tag),
        .o_victim_line  (victim_line)
    );

    cache_controller #(
        .SET_BITS       (SET_BITS)
    ) ctrl_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_read         (i_read),
        .i_write        (i_write),
        .i_addr         (i_addr),
        .i_hit          (hit),
        .i_victim_dirty (victim_dirty),
        .i_victim_tag   (victim_tag),
        .i_victim_line  (victim_line),
        .i_mem_ready    (i_mem_ready),
        .o_stall        (o_stall),
        .o_mem_read     (o_mem_read),
        .o_mem_write    (o_mem_write),
        .o_mem_addr     (o_mem_addr),
        .o_mem_wdata    (o_mem_wdata),
        .o_fill_cmd     (fill_cmd)
    );

endmodule

// File: testbench/l1_dcache_tests.svh
// Counts of NO_CHECK are not predicted; only word addresses below 0x100 are modeled
task automatic load_tests();
    // op, word address, write data, memory reads, memory writes, write-back line, name
    add_entry(OP_READ,  30'h004, 32'h0,         1, 0, 28'h0, "read miss line 1");
    add_entry(OP_READ,  30'h007, 32'h0,         0, 0, 28'h0, "read hit same line");
    add_entry(OP_WRITE, 30'h005, 32'hDEAD_BEEF, 0, 0, 28'h0, "write hit line 1");
    add_entry(OP_READ,  30'h005, 32'h0,         0, 0, 28'h0, "read back write hit");
    add_entry(OP_READ,  30'h014, 32'h0,         1, 0, 28'h0, "fill second way line 5");
    add_entry(OP_READ,  30'h024, 32'h0,         1, 1, 28'h1, "dirty victim line 1");
    add_entry(OP_READ,  30'h034, 32'h0,         1, 0, 28'h0, "clean victim line 5");
    // Set 2 holds lines 2, 6 and 10
    add_entry(OP_WRITE, 30'h019, 32'h1234_5678, 1, 0, 28'h0, "write miss line 6");
    add_entry(OP_READ,  30'h019, 32'h0,         0, 0, 28'h0, "read back write miss");
    add_entry(OP_READ,  30'h008, 32'h0,         1, 0, 28'h0, "fill second way line 2");
    add_entry(OP_READ,  30'h02A, 32'h0,         1, 1, 28'h6, "evict allocated line 6");
    add_entry(OP_READ,  30'h01B, 32'h0,         1, 0, 28'h0, "refetch line 6");
    add_entry(OP_READ,  30'h019, 32'h0,         0, 0, 28'h0, "written word from memory");
    add_entry(OP_RAND,  30'h000, 32'h0, NO_CHECK, NO_CHECK, 28'h0, "random mix");
    // Two fresh lines per set push every dirty line out
    add_entry(OP_READ,  30'h080, 32'h0, 1, NO_CHECK, 28'h0, "flush set 0 first");
    add_entry(OP_READ,  30'h084, 32'h0, 1, NO_CHECK, 28'h0, "flush set 1 first");
    add_entry(OP_READ,  30'h088, 32'h0, 1, NO_CHECK, 28'h0, "flush set 2 first");
    add_entry(OP_READ,  30'h08C, 32'h0, 1, NO_CHECK, 28'h0, "flush set 3 first");
    add_entry(OP_READ,  30'h090, 32'h0, 1, NO_CHECK, 28'h0, "flush set 0 second");
    add_entry(OP_READ,  30'h094, 32'h0, 1, NO_CHECK, 28'h0, "flush set 1 second");
    add_entry(OP_READ,  30'h098, 32'h0, 1, NO_CHECK, 28'h0, "flush set 2 second");
    add_entry(OP_READ,  30'h09C, 32'h0, 1, NO_CHECK, 28'h0, "flush set 3 second");
endtask

// File: testbench/l1_dcache_tb.sv
// Memory model answers after a fixed latency and only holds the lowest 64 lines
`timescale 1ns/1ps

module l1_dcache_tb;

    localparam int SET_BITS    = 2;
    localparam int MEM_LATENCY = 3;    // Cycles from request to ready
    localparam int MEM_WORDS   = 256;  // 64 lines
    localparam int RAND_COUNT  = 48;
    localparam int OP_READ     = 0;
    localparam int OP_WRITE    = 1;
    localparam int OP_RAND     = 2;
    localparam int NO_CHECK    = 15;

    logic         clk;
    logic         rst_n;
    logic         i_read;
    logic         i_write;
    logic [29:0]  i_addr;
    logic [31:0]  i_wdata;
    logic [31:0]  o_rdata;
    logic         o_stall;
    logic         o_mem_read;
    logic         o_mem_write;
    logic [27:0]  o_mem_addr;
    logic [127:0] o_mem_wdata;
    logic [127:0] i_mem_rdata = '0;
    logic         i_mem_ready = 1'b0;

    int          tbl_op[$];
    logic [29:0] tbl_addr[$];
    logic [31:0] tbl_wdata[$];
    int          tbl_rd[$];
    int          tbl_wr[$];
    logic [27:0] tbl_wb[$];
    string       tbl_name[$];

    logic [31:0] mem_words [MEM_WORDS];
    logic [31:0] shadow    [MEM_WORDS];  // Processor view
    logic [27:0] last_wb_line;
    int mem_rd_cnt;
    int mem_wr_cnt;
    int mem_errors;
    int wait_cnt;
    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycle_cnt = 0;
    int timeout_limit = 0;

    l1_dcache #(.SET_BITS(SET_BITS)) l1_dcache_i (
        .clk(clk), .rst_n(rst_n), .i_read(i_read), .i_write(i_write),
        .i_addr(i_addr), .i_wdata(i_wdata), .o_rdata(o_rdata), .o_stall(o_stall),
        .o_mem_read(o_mem_read), .o_mem_write(o_mem_write), .o_mem_addr(o_mem_addr),
        .o_mem_wdata(o_mem_wdata), .i_mem_rdata(i_mem_rdata), .i_mem_ready(i_mem_ready)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (timeout_limit > 0 && cycle_cnt > timeout_limit) begin
            $display("ERROR: run timed out after %0d cycles waiting on the cache", cycle_cnt);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Initial memory contents, a function of the whole word address
    function automatic logic [31:0] fill_word(input logic [29:0] waddr);
        return {waddr[13:0], waddr[29:14], 2'b01} ^ 32'hA5C3_0F96;
    endfunction

    function automatic int total_errors();
        return errors + mem_errors;
    endfunction

    task automatic add_entry(input int op, input logic [29:0] addr, input logic [31:0] wdata,
                             input int rd, input int wr, input logic [27:0] wb, input string name);
        tbl_op.push_back(op);
        tbl_addr.push_back(addr);
        tbl_wdata.push_back(wdata);
        tbl_rd.push_back(rd);
        tbl_wr.push_back(wr);
        tbl_wb.push_back(wb);
        tbl_name.push_back(name);
    endtask

    `include "l1_dcache_tests.svh"

    // ------------------------------------------------------------
    // Memory model
    // ------------------------------------------------------------
    task automatic serve_request();
        int          base;
        logic [127:0] exp_line;
        base = int'(o_mem_addr) * 4;
        if (o_mem_addr >= MEM_WORDS / 4) begin
            $display("ERROR: memory request to line 0x%h is outside the model", o_mem_addr);
            mem_errors++;
            return;
        end
        if (o_mem_write) begin
            exp_line = {shadow[base+3], shadow[base+2], shadow[base+1], shadow[base]};
            if (o_mem_wdata !== exp_line) begin
                $display("FAIL o_mem_wdata line 0x%h: expected 0x%h got 0x%h",
                         o_mem_addr, exp_line, o_mem_wdata);
                mem_errors++;
            end
            for (int w = 0; w < 4; w++) begin
                mem_words[base+w] = o_mem_wdata[w*32 +: 32];
            end
            last_wb_line = o_mem_addr;
            mem_wr_cnt++;
        end else begin
            if (o_mem_addr !== i_addr[29:2]) begin
                $display("FAIL o_mem_addr: expected 0x%h got 0x%h", i_addr[29:2], o_mem_addr);
                mem_errors++;
            end
            i_mem_rdata = {mem_words[base+3], mem_words[base+2], mem_words[base+1],
                           mem_words[base]};
            mem_rd_cnt++;
        end
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            for (int a = 0; a < MEM_WORDS; a++) begin
                mem_words[a] = fill_word(a);
            end
            i_mem_ready = 1'b0;
            wait_cnt    = 0;
            mem_rd_cnt  = 0;
            mem_wr_cnt  = 0;
            mem_errors  = 0;
        end else if (i_mem_ready) begin
            i_mem_ready = 1'b0;  // One cycle pulse
            wait_cnt    = 0;
        end else if (o_mem_read || o_mem_write) begin
            if (wait_cnt < MEM_LATENCY - 1) begin
                wait_cnt++;
            end else begin
                serve_request();
                i_mem_ready = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Processor side
    // ------------------------------------------------------------
    task automatic check_access(input bit is_wr, input logic [29:0] addr,
                                input logic [31:0] wdata, output bit stalled);
        logic [31:0] rdata;
        stalled = 1'b0;
        @(negedge clk);
        i_read  = !is_wr;
        i_write = is_wr;
        i_addr  = addr;
        i_wdata = wdata;
        #1;
        while (o_stall) begin
            stalled = 1'b1;
            @(negedge clk);
            #1;
        end
        rdata = o_rdata;  // Access completes on the coming edge
        @(negedge clk);
        i_read  = 1'b0;
        i_write = 1'b0;
        if (is_wr) begin
            shadow[addr[7:0]] = wdata;
            if (rdata !== 32'h0) begin
                $display("FAIL o_rdata on write 0x%h: expected 0x0 got 0x%h", addr, rdata);
                errors++;
            end
        end else if (rdata !== shadow[addr[7:0]]) begin
            $display("FAIL o_rdata at 0x%h: expected 0x%h got 0x%h", addr, shadow[addr[7:0]], rdata);
            errors++;
        end
    endtask

    task automatic check_mem_traffic(input int t, input int rd0, input int wr0);
        if (tbl_rd[t] != NO_CHECK && mem_rd_cnt - rd0 != tbl_rd[t]) begin
            $display("FAIL o_mem_read count: expected 0x%h got 0x%h", tbl_rd[t], mem_rd_cnt - rd0);
            errors++;
        end
        if (tbl_wr[t] != NO_CHECK && mem_wr_cnt - wr0 != tbl_wr[t]) begin
            $display("FAIL o_mem_write count: expected 0x%h got 0x%h", tbl_wr[t], mem_wr_cnt - wr0);
            errors++;
        end else if (tbl_wr[t] == 1 && last_wb_line !== tbl_wb[t]) begin
            $display("FAIL o_mem_addr write-back: expected 0x%h got 0x%h", tbl_wb[t], last_wb_line);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        if (total_errors() == err0) begin
            tests_passed++;
            $display("test %-26s passed", name);
        end else begin
            tests_failed++;
            $display("test %-26s failed with %0d errors", name, total_errors() - err0);
        end
    endtask

    initial begin
        int          seed;
        int          rd0;
        int          wr0;
        int          err0;
        int          n_entries;
        logic [31:0] rnd;
        bit          stalled;
        bit          exp_stall;
        clk = 1'b0;
        rst_n = 1'b0;
        i_read = 1'b0;
        i_write = 1'b0;
        i_addr = '0;
        i_wdata = '0;
        seed = 32'h0bd693d0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            shadow[a] = fill_word(a);
        end
        load_tests();
        n_entries = 0;
        foreach (tbl_op[k]) begin
            n_entries += (tbl_op[k] == OP_RAND) ? RAND_COUNT : 1;
        end
        timeout_limit = n_entries * 2 * (MEM_LATENCY + 3) + 100;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        err0 = total_errors();
        if (o_mem_read !== 1'b0 || o_mem_write !== 1'b0) begin
            $display("FAIL o_mem_read/o_mem_write after reset: expected 0x0 got 0x%h 0x%h",
                     o_mem_read, o_mem_write);
            errors++;
        end
        if (o_stall !== 1'b0) begin
            $display("FAIL o_stall idle: expected 0x0 got 0x%h", o_stall);
            errors++;
        end
        report_test("reset state", err0);
        for (int t = 0; t < tbl_op.size(); t++) begin
            rd0  = mem_rd_cnt;
            wr0  = mem_wr_cnt;
            err0 = total_errors();
            if (tbl_op[t] == OP_RAND) begin
                for (int r = 0; r < RAND_COUNT; r++) begin
                    rnd = $random(seed);
                    // Lines 0 to 15
                    check_access(rnd[0], {24'h0, rnd[6:1]}, $random(seed), stalled);
                end
            end else begin
                check_access(tbl_op[t] == OP_WRITE, tbl_addr[t], tbl_wdata[t], stalled);
                check_mem_traffic(t, rd0, wr0);
                exp_stall = (tbl_rd[t] != 0);  // A miss always refills
                if (tbl_rd[t] != NO_CHECK && stalled !== exp_stall) begin
                    $display("FAIL o_stall seen: expected 0x%h got 0x%h", exp_stall, stalled);
                    errors++;
                end
            end
            report_test(tbl_name[t], err0);
        end
        err0 = total_errors();
        for (int a = 0; a < MEM_WORDS; a++) begin
            if (mem_words[a] !== shadow[a]) begin
                $display("FAIL mem_words[0x%h]: expected 0x%h got 0x%h", a, shadow[a], mem_words[a]);
                errors++;
            end
        end
        report_test("memory matches shadow", err0);
        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: l1_dcache.f
+incdir+testbench
source/cache_layout_pkg.sv
source/cache_ctrl_pkg.sv
source/cache_ways.sv
source/cache_controller.sv
source/l1_dcache.sv
testbench/l1_dcache_tb.sv
